/* src/mb_mult_pkg.sv */
package mb_mult_pkg;

   // Operand and product widths
   localparam int MULT_W = 16;
   localparam int PROD_W = 2 * MULT_W;

   // Radix-8 recoding consumes three multiplier bits per group
   localparam int GROUP_BITS = 3;
   localparam int GROUP_CNT  = 6;

   // Widest selected multiple (3Y and 4Y both need two extra bits)
   localparam int TRIPLE_W = MULT_W + 2;

   // Six partial products and the sign-extension correction word
   localparam int NUM_ROWS = GROUP_CNT + 1;

   // Clock edges from accepted operands to a valid product
   localparam int PIPE_LAT = 2;

   typedef logic [MULT_W-1:0]    mult_t;
   typedef logic [PROD_W-1:0]    prod_t;
   typedef logic [GROUP_CNT-1:0] group_t;

   // Rows are already shifted to their final weight
   typedef prod_t [NUM_ROWS-1:0] pp_rows_t;

endpackage

/* src/booth_encoder.sv */
`timescale 1ns/10ps

module booth_encoder (
   input  mb_mult_pkg::mult_t  mx,
   output mb_mult_pkg::group_t group_single,
   output mb_mult_pkg::group_t group_double,
   output mb_mult_pkg::group_t group_triple,
   output mb_mult_pkg::group_t group_quad,
   output mb_mult_pkg::group_t group_neg
);

   import mb_mult_pkg::*;

   // Multiplier with a zero below bit 0 and zero padding above the MSB
   logic [GROUP_CNT*GROUP_BITS:0] mx_ext;

   assign mx_ext = {{(GROUP_CNT * GROUP_BITS - MULT_W){1'b0}}, mx, 1'b0};

   for (genvar g = 0; g < GROUP_CNT; g++) begin : gen_group
      logic [GROUP_BITS:0] win;
      logic                x01;
      logic                x12;
      logic                x23;

      // Three new bits plus the top bit of the group below
      assign win = mx_ext[GROUP_BITS*g +: GROUP_BITS+1];

      assign x01 = win[0] ^ win[1];
      assign x12 = win[1] ^ win[2];
      assign x23 = win[2] ^ win[3];

      // Digit = -4*w3 + 2*w2 + w1 + w0, all-equal windows give zero
      assign group_single[g] = x01 & ~x23;
      assign group_double[g] = x12 & ~x01;
      assign group_triple[g] = x23 & x01;
      assign group_quad[g]   = x23 & ~x01 & ~x12;
      assign group_neg[g]    = win[3];
   end

endmodule

/* src/booth_pp_gen.sv */
`timescale 1ns/10ps

module booth_pp_gen (
   input  mb_mult_pkg::mult_t    my,
   input  mb_mult_pkg::group_t   group_single,
   input  mb_mult_pkg::group_t   group_double,
   input  mb_mult_pkg::group_t   group_triple,
   input  mb_mult_pkg::group_t   group_quad,
   input  mb_mult_pkg::group_t   group_neg,
   output mb_mult_pkg::pp_rows_t pp_rows
);

   import mb_mult_pkg::*;

   logic [TRIPLE_W-1:0] y_1x;
   logic [TRIPLE_W-1:0] y_2x;
   logic [TRIPLE_W-1:0] y_3x;
   logic [TRIPLE_W-1:0] y_4x;
   prod_t               corr;

   assign y_1x = {{(TRIPLE_W - MULT_W){1'b0}}, my};
   assign y_2x = y_1x << 1;
   assign y_4x = y_1x << 2;

   // The hard multiple is shared by every group
   assign y_3x = y_1x + y_2x;

   for (genvar g = 0; g < GROUP_CNT; g++) begin : gen_row
      logic [TRIPLE_W-1:0] mag;
      logic [TRIPLE_W-1:0] sel;

      assign mag = ({TRIPLE_W{group_single[g]}} & y_1x) |
                   ({TRIPLE_W{group_double[g]}} & y_2x) |
                   ({TRIPLE_W{group_triple[g]}} & y_3x) |
                   ({TRIPLE_W{group_quad[g]}}   & y_4x);

      // One's complement here, the +1 comes in through the correction word
      assign sel = mag ^ {TRIPLE_W{group_neg[g]}};

      // Inverted sign sits just above the selected multiple
      assign pp_rows[g] = prod_t'({~group_neg[g], sel}) << (GROUP_BITS * g);
   end

   always_comb begin
      corr = '0;
      // Each row's sign bit is biased by -2^(TRIPLE_W + 3g); terms past the
      // product width wrap away
      for (int j = 0; j < GROUP_CNT; j++) begin
         corr = corr - (prod_t'(1) << (TRIPLE_W + GROUP_BITS * j));
      end
      // Negate bits land below TRIPLE_W so they never collide with the bias
      for (int j = 0; j < GROUP_CNT; j++) begin
         corr = corr | (prod_t'(group_neg[j]) << (GROUP_BITS * j));
      end
   end

   assign pp_rows[NUM_ROWS-1] = corr;

endmodule

/* src/wallace_tree.sv */
`timescale 1ns/10ps

module wallace_tree (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  in_valid,
   input  mb_mult_pkg::pp_rows_t pp_rows,
   output mb_mult_pkg::prod_t    cs_sum,
   output mb_mult_pkg::prod_t    cs_carry,
   output logic                  cs_valid
);

   import mb_mult_pkg::*;

   // Word-wide 3:2 compressor, index 0 is the sum and index 1 the carry
   function automatic logic [1:0][PROD_W-1:0] csa(
      input prod_t a,
      input prod_t b,
      input prod_t c
   );
      logic [1:0][PROD_W-1:0] res;
      res[0] = a ^ b ^ c;
      res[1] = ((a & b) | (a & c) | (b & c)) << 1;
      return res;
   endfunction

   prod_t lvl1 [5];
   prod_t lvl2 [4];
   prod_t lvl3 [3];
   prod_t lvl4 [2];

   always_comb begin
      // Level 1 takes the six partial products in two groups of three
      {lvl1[1], lvl1[0]} = csa(pp_rows[0], pp_rows[1], pp_rows[2]);
      {lvl1[3], lvl1[2]} = csa(pp_rows[3], pp_rows[4], pp_rows[5]);
      lvl1[4]            = pp_rows[6];

      {lvl2[1], lvl2[0]} = csa(lvl1[0], lvl1[1], lvl1[2]);
      lvl2[2]            = lvl1[3];
      lvl2[3]            = lvl1[4];

      {lvl3[1], lvl3[0]} = csa(lvl2[0], lvl2[1], lvl2[2]);
      lvl3[2]            = lvl2[3];

      // Last level leaves the redundant pair for the carry-propagate adder
      {lvl4[1], lvl4[0]} = csa(lvl3[0], lvl3[1], lvl3[2]);
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cs_valid <= 1'b0;
      end else begin
         cs_valid <= in_valid;
      end
   end

   // Pair holds its last value between valid operands
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cs_sum   <= '0;
         cs_carry <= '0;
      end else if (in_valid) begin
         cs_sum   <= lvl4[0];
         cs_carry <= lvl4[1];
      end
   end

endmodule

/* src/prefix_adder.sv */
`timescale 1ns/10ps

module prefix_adder (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               cs_valid,
   input  mb_mult_pkg::prod_t cs_sum,
   input  mb_mult_pkg::prod_t cs_carry,
   output mb_mult_pkg::prod_t product,
   output logic               out_valid
);

   import mb_mult_pkg::*;

   // Group generate per level, level 0 is the per-bit generate
   prod_t g_lvl [$clog2(PROD_W)+1];
   // Group propagate, not needed after the last level
   prod_t p_lvl [$clog2(PROD_W)];
   prod_t half_sum;
   prod_t carry_in;
   prod_t sum;

   assign g_lvl[0] = cs_sum & cs_carry;
   assign p_lvl[0] = cs_sum ^ cs_carry;
   assign half_sum = p_lvl[0];

   // Kogge-Stone tree with spans 1, 2, 4, 8 and 16
   for (genvar l = 0; l < $clog2(PROD_W); l++) begin : gen_level
      assign g_lvl[l+1] = g_lvl[l] | (p_lvl[l] & (g_lvl[l] << (1 << l)));
      if (l < $clog2(PROD_W) - 1) begin : gen_prop
         // Low bits shift in zero, their groups already reach bit 0
         assign p_lvl[l+1] = p_lvl[l] & (p_lvl[l] << (1 << l));
      end
   end

   // Carry into bit i is the group generate of bits i-1 down to 0
   // The top generate would be the carry-out, which has no place in the product
   assign carry_in = {g_lvl[$clog2(PROD_W)][PROD_W-2:0], 1'b0};
   assign sum      = half_sum ^ carry_in;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= cs_valid;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         product <= '0;
      end else if (cs_valid) begin
         product <= sum;
      end
   end

endmodule

/* src/mb_mult_top.sv */
`timescale 1ns/10ps

module mb_mult_top (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               in_valid,
   input  mb_mult_pkg::mult_t mx,
   input  mb_mult_pkg::mult_t my,
   output logic               out_valid,
   output mb_mult_pkg::prod_t product
);

   import mb_mult_pkg::*;

   group_t   group_single;
   group_t   group_double;
   group_t   group_triple;
   group_t   group_quad;
   group_t   group_neg;
   pp_rows_t pp_rows;
   prod_t    cs_sum;
   prod_t    cs_carry;
   logic     cs_valid;

   // Recoding and row selection are combinational ahead of the first register
   booth_encoder u_enc (
      .mx           (mx),
      .group_single (group_single),
      .group_double (group_double),
      .group_triple (group_triple),
      .group_quad   (group_quad),
      .group_neg    (group_neg)
   );

   booth_pp_gen u_ppg (
      .my           (my),
      .group_single (group_single),
      .group_double (group_double),
      .group_triple (group_triple),
      .group_quad   (group_quad),
      .group_neg    (group_neg),
      .pp_rows      (pp_rows)
   );

   wallace_tree u_wal (
      .clk      (clk),
      .arst_n   (arst_n),
      .in_valid (in_valid),
      .pp_rows  (pp_rows),
      .cs_sum   (cs_sum),
      .cs_carry (cs_carry),
      .cs_valid (cs_valid)
   );

   prefix_adder u_add (
      .clk       (clk),
      .arst_n    (arst_n),
      .cs_valid  (cs_valid),
      .cs_sum    (cs_sum),
      .cs_carry  (cs_carry),
      .product   (product),
      .out_valid (out_valid)
   );

endmodule

/* dv/mb_mult_props.sv */
`timescale 1ns/10ps

module mb_mult_props (
   input logic               clk,
   input logic               arst_n,
   input logic               in_valid,
   input logic               out_valid,
   input mb_mult_pkg::prod_t product
);

   import mb_mult_pkg::*;

   // Every accepted operand produces one result after a fixed number of edges
   a_latency: assert property (@(posedge clk) disable iff (!arst_n)
                               out_valid == $past(in_valid, PIPE_LAT))
      else $error("out_valid does not follow in_valid by %0d edges", PIPE_LAT);

   a_reset_valid: assert property (@(posedge clk) !arst_n |-> !out_valid)
      else $error("out_valid high while reset is asserted");

   // The product register loads only together with the valid strobe
   a_hold: assert property (@(posedge clk) disable iff (!arst_n)
                            !out_valid |-> $stable(product))
      else $error("product changed while out_valid was low");

endmodule

bind mb_mult_top mb_mult_props u_props (
   .clk       (clk),
   .arst_n    (arst_n),
   .in_valid  (in_valid),
   .out_valid (out_valid),
   .product   (product)
);

/* dv/mb_mult_tb.sv */
`timescale 1ns/10ps

module mb_mult_tb;

   import mb_mult_pkg::*;

   localparam int CLK_PERIOD = 100;
   localparam int RST_CYCLES = 10;
   localparam int SEED       = 65675;
   localparam int N_DIR      = 15;
   localparam int N_RAND     = 40;
   localparam int TBL_LEN    = N_DIR + N_RAND;

   logic  clk;
   logic  arst_n;
   logic  in_valid;
   mult_t mx;
   mult_t my;
   logic  out_valid;
   prod_t product;

   // Stimulus table with idle cycles before each entry and a mid-stream reset flag
   string t_name [TBL_LEN];
   mult_t t_mx   [TBL_LEN];
   mult_t t_my   [TBL_LEN];
   prod_t t_exp  [TBL_LEN];
   int    t_idle [TBL_LEN];
   bit    t_rst  [TBL_LEN];
   int    n_tbl = 0;

   // Issued operations, oldest first, with the edge count at which each is due
   string sb_name [$];
   prod_t sb_exp  [$];
   int    sb_due  [$];

   int edge_cnt     = 0;
   int limit_cycles = 0;
   bit tbl_ready    = 1'b0;

   mb_mult_top u_dut (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .mx        (mx),
      .my        (my),
      .out_valid (out_valid),
      .product   (product)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      edge_cnt <= edge_cnt + 1;
   end

   task automatic check_prod(input string name, input prod_t exp, input prod_t act);
      if (act !== exp) begin
         $display("mismatch %s: expected %08h actual %08h", name, exp, act);
         $display("TB FAILED");
         $fatal(1, "product check failed");
      end
   endtask

   task automatic check_valid(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("mismatch %s: expected %b actual %b", name, exp, act);
         $display("TB FAILED");
         $fatal(1, "valid check failed");
      end
   endtask

   task automatic add_entry(input string name, input mult_t a, input mult_t b,
                            input int idle, input bit rst);
      t_name[n_tbl] = name;
      t_mx[n_tbl]   = a;
      t_my[n_tbl]   = b;
      // The product of two unsigned operands in full 32-bit width
      t_exp[n_tbl]  = prod_t'(a) * prod_t'(b);
      t_idle[n_tbl] = idle;
      t_rst[n_tbl]  = rst;
      n_tbl++;
   endtask

   task automatic build_table();
      add_entry("zero_x_ffff", 16'h0000, 16'hFFFF, 0, 1'b0);
      add_entry("ffff_x_zero", 16'hFFFF, 16'h0000, 0, 1'b0);
      add_entry("one_x_ffff", 16'h0001, 16'hFFFF, 0, 1'b0);
      add_entry("ffff_x_ffff", 16'hFFFF, 16'hFFFF, 0, 1'b0);
      add_entry("pow2_8000_x_8000", 16'h8000, 16'h8000, 0, 1'b0);
      add_entry("pow2_0100_x_1234", 16'h0100, 16'h1234, 0, 1'b0);
      add_entry("pow2_0008_x_ffff", 16'h0008, 16'hFFFF, 0, 1'b0);
      // Repeating patterns walk the Booth digits through -4 to +4
      add_entry("digits_3333_x_abcd", 16'h3333, 16'hABCD, 0, 1'b0);
      add_entry("digits_5555_x_5555", 16'h5555, 16'h5555, 0, 1'b0);
      add_entry("digits_db6d_x_ffff", 16'hDB6D, 16'hFFFF, 0, 1'b0);
      add_entry("digits_9249_x_7fff", 16'h9249, 16'h7FFF, 0, 1'b0);
      add_entry("digits_cccc_x_9249", 16'hCCCC, 16'h9249, 0, 1'b0);
      add_entry("digits_aaaa_x_db6d", 16'hAAAA, 16'hDB6D, 0, 1'b0);
      add_entry("digits_7fff_x_8001", 16'h7FFF, 16'h8001, 0, 1'b0);
      // Groups 1 and 4 see 0111 and decode to +4
      add_entry("digits_381c_x_c3a5", 16'h381C, 16'hC3A5, 0, 1'b0);
      // First half back to back, second half with random gaps and one reset
      for (int i = 0; i < N_RAND; i++) begin
         add_entry($sformatf("rand_%0d", i), mult_t'($urandom()), mult_t'($urandom()),
                   (i >= N_RAND / 2 && $urandom() % 3 == 0) ? int'($urandom() % 3) + 1 : 0,
                   i == (N_RAND * 3) / 4);
      end
   endtask

   task automatic apply_mid_reset();
      @(posedge clk);
      in_valid <= 1'b0;
      arst_n   <= 1'b0;
      // Operations still in the pipe are lost with the reset
      sb_name.delete();
      sb_exp.delete();
      sb_due.delete();
      repeat (3) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);
   endtask

   // Outputs settle after the rising edge, so they are compared at the falling edge
   always @(negedge clk) begin
      logic  exp_v;
      string pend;
      exp_v = 1'b0;
      pend  = "idle";
      if (sb_due.size() > 0) begin
         pend = sb_name[0];
         if (sb_due[0] == edge_cnt) exp_v = 1'b1;
      end
      check_valid($sformatf("%s out_valid at edge %0d", pend, edge_cnt), exp_v, out_valid);
      if (out_valid) begin
         check_prod(sb_name[0], sb_exp[0], product);
         void'(sb_name.pop_front());
         void'(sb_exp.pop_front());
         void'(sb_due.pop_front());
      end
   end

   initial begin
      wait (tbl_ready);
      #(limit_cycles * CLK_PERIOD);
      $display("ERROR: watchdog expired after %0d clock cycles", limit_cycles);
      $display("TB FAILED");
      $fatal(1, "timeout");
   end

   initial begin
      arst_n   = 1'b0;
      in_valid = 1'b0;
      mx       = '0;
      my       = '0;
      void'($urandom(SEED));
      build_table();
      limit_cycles = RST_CYCLES + PIPE_LAT + 20;
      for (int i = 0; i < n_tbl; i++) begin
         limit_cycles += 1 + t_idle[i] + (t_rst[i] ? 6 : 0);
      end
      tbl_ready = 1'b1;

      repeat (RST_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
      repeat (2) @(posedge clk);

      for (int i = 0; i < n_tbl; i++) begin
         if (t_rst[i]) apply_mid_reset();
         repeat (t_idle[i]) begin
            @(posedge clk);
            in_valid <= 1'b0;
         end
         @(posedge clk);
         in_valid <= 1'b1;
         mx       <= t_mx[i];
         my       <= t_my[i];
         sb_name.push_back(t_name[i]);
         sb_exp.push_back(t_exp[i]);
         // edge_cnt has not yet counted this edge
         // The result is due PIPE_LAT edges after it
         sb_due.push_back(edge_cnt + 1 + PIPE_LAT);
      end
      @(posedge clk);
      in_valid <= 1'b0;

      while (sb_exp.size() != 0) @(posedge clk);
      repeat (PIPE_LAT + 2) @(posedge clk);

      $display("TB PASSED");
      $finish;
   end

endmodule

/* mb_mult.f */
src/mb_mult_pkg.sv
src/booth_encoder.sv
src/booth_pp_gen.sv
src/wallace_tree.sv
src/prefix_adder.sv
src/mb_mult_top.sv
dv/mb_mult_props.sv
dv/mb_mult_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile the multiplier and its testbench with Verilator, run, and check the log
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module mb_mult_tb -Mdir obj_dir -f mb_mult.f

status=0
./obj_dir/Vmb_mult_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
   echo "Simulation failed"
   exit 1
fi
if [ "$status" -ne 0 ]; then
   echo "Simulator exited with status $status"
   exit 1
fi
echo "Simulation passed"
